//--- bench/mipsCases.txt
# tag address value, all hex; P program word, D preset data word
# S expected store in program order, E end pc with address only
P 00000000 20010007 # addi $1, $0, 7
P 00000004 2002FFFD # addi $2, $0, -3
P 00000008 00221820 # add $3, $1, $2
P 0000000C AC030000 # sw $3, 0($0)
P 00000010 00412022 # sub $4, $2, $1
P 00000014 AC040004 # sw $4, 4($0)
P 00000018 00222824 # and $5, $1, $2
P 0000001C AC050008 # sw $5, 8($0)
P 00000020 00223025 # or $6, $1, $2
P 00000024 AC06000C # sw $6, 12($0)
P 00000028 0041382A # slt $7, $2, $1
P 0000002C AC070010 # sw $7, 16($0)
P 00000030 8C080100 # lw $8, 0x100($0)
P 00000034 AC080014 # sw $8, 20($0)
P 00000038 20000005 # addi $0, $0, 5
P 0000003C AC000018 # sw $0, 24($0)
P 00000040 AC1D001C # sw $29, 28($0)
P 00000044 10210001 # beq $1, $1, +1 taken
P 00000048 AC010020 # sw $1, 32($0) skipped
P 0000004C 10220001 # beq $1, $2, +1 not taken
P 00000050 AC010024 # sw $1, 36($0)
P 00000054 08000017 # j 0x5C
P 00000058 AC020028 # sw $2, 40($0) skipped
P 0000005C 8C090104 # lw $9, 0x104($0)
P 00000060 8C0A0108 # lw $10, 0x108($0)
P 00000064 7D2A5810 # addu.qb $11, $9, $10
P 00000068 AC0B0028 # sw $11, 40($0)
P 0000006C 7D2A6110 # addu_s.qb $12, $9, $10
P 00000070 AC0C002C # sw $12, 44($0)
P 00000074 FC030055 # undefined opcode
P 00000078 AC030030 # sw $3, 48($0)
D 00000100 CAFEF00D
D 00000104 80FF7F10
D 00000108 90018020
S 00000000 00000004
S 00000004 FFFFFFF6
S 00000008 00000005
S 0000000C FFFFFFFF
S 00000010 00000001
S 00000014 CAFEF00D
S 00000018 00000000
S 0000001C 00004000
S 00000024 00000007
S 00000028 1000FF30
S 0000002C FFFFFF30
S 00000030 00000004
E 0000007C

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;

	localparam int period        = 40;
	localparam int memDepth      = 256;                        // words per memory
	localparam int timeoutMargin = 20;
	localparam int maxStores     = 64;

	logic        clk = 1'b0;
	logic        reset;
	logic [31:0] instruction;
	logic [31:0] dataFromMem;
	logic [31:0] pc;
	logic        writeEnable;
	logic [31:0] addressToMem;
	logic [31:0] dataToMem;

	logic [31:0] imem [memDepth];
	logic [31:0] dmem [memDepth];
	logic [31:0] storeAddr [maxStores];
	logic [31:0] storeData [maxStores];
	logic [31:0] endPc;
	logic [31:0] fetchPc;                                      // pc of the word on instruction
	int          storeCount;
	int          storeIdx;
	int          progCount;
	int          cycleCount;
	int          seed = 15319;

	mipsCore dut (
		.clk          (clk),
		.reset        (reset),
		.pc           (pc),
		.instruction  (instruction),
		.writeEnable  (writeEnable),
		.addressToMem (addressToMem),
		.dataToMem    (dataToMem),
		.dataFromMem  (dataFromMem)
	);

	always #(period / 2) clk = ~clk;

	function automatic int wordIndex(input logic [31:0] addr);
		return int'((addr >> 2) % memDepth);
	endfunction

	task automatic stopRun();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, expected, actual);
		stopRun();
	endtask

	// ------------------------------------------------------------
	// memory models and the cases file
	// ------------------------------------------------------------
	task automatic fillMemories();
		for (int idx = 0; idx < memDepth; idx++) begin
			imem[idx] = '0;                                     // all-zero word decodes as a nop
			dmem[idx] = $random(seed);
		end
	endtask

	task automatic loadCases();
		int               fd;
		int               code;
		logic [7:0]       tag;
		logic [31:0]      addr;
		logic [31:0]      value;
		logic [8*128-1:0] rest;

		fd = $fopen("bench/mipsCases.txt", "r");
		assert (fd != 0) else begin
			$display("could not open bench/mipsCases.txt");
			stopRun();
		end
		code = $fscanf(fd, "%s", tag);
		while (code == 1) begin
			if (tag == "#") begin
				code = $fgets(rest, fd);                        // skip to end of line
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h", endPc);
			end else begin
				code = $fscanf(fd, "%h %h", addr, value);
				assert (code == 2) else begin
					$display("malformed line with tag %s in the cases file", tag);
					stopRun();
				end
				case (tag)
					"P": begin
						imem[wordIndex(addr)] = value;
						progCount++;
					end
					"D": dmem[wordIndex(addr)] = value;
					"S": begin
						storeAddr[storeCount] = addr;
						storeData[storeCount] = value;
						storeCount++;
					end
					default: begin
						$display("unknown tag %s in the cases file", tag);
						stopRun();
					end
				endcase
			end
			code = $fscanf(fd, "%s", tag);
		end
		$fclose(fd);
	endtask

	task automatic driveInputs();
		fetchPc     = pc;
		instruction = imem[wordIndex(pc)];
		#1;
		dataFromMem = dmem[wordIndex(addressToMem)];           // address follows the new word
	endtask

	// ------------------------------------------------------------
	// checkers
	// ------------------------------------------------------------
	task automatic checkStore();
		assert (storeIdx < storeCount) else begin
			$display("unexpected store at time %0t to address %h", $time, addressToMem);
			stopRun();
		end
		assert (addressToMem == storeAddr[storeIdx])
			else reportMismatch("addressToMem", storeAddr[storeIdx], addressToMem);
		assert (dataToMem == storeData[storeIdx])
			else reportMismatch("dataToMem", storeData[storeIdx], dataToMem);
		dmem[wordIndex(addressToMem)] = dataToMem;
		storeIdx++;
	endtask

	task automatic checkPcStep(input logic [31:0] prevPc, input logic [31:0] prevInstr);
		logic [31:0] seqPc;
		logic [31:0] takenPc;
		logic [31:0] jumpPc;

		seqPc   = prevPc + 32'd4;
		takenPc = seqPc + {{14{prevInstr[15]}}, prevInstr[15:0], 2'b00};
		jumpPc  = {seqPc[31:28], prevInstr[25:0], 2'b00};
		if (prevInstr[31:26] == opJ) begin
			assert (pc == jumpPc) else reportMismatch("pc", jumpPc, pc);
		end else if (prevInstr[31:26] == opBeq) begin
			assert (pc == seqPc || pc == takenPc) else begin
				$display("pc %h after the beq at %h is neither fall-through nor target",
					pc, prevPc);
				stopRun();
			end
		end else begin
			assert (pc == seqPc) else reportMismatch("pc", seqPc, pc);
		end
	endtask

	initial begin
		bit finished;

		reset       = 1'b1;
		instruction = {opSw, 26'd0};                            // sw held during reset
		dataFromMem = '0;
		fetchPc     = '0;
		endPc       = '0;
		storeCount  = 0;
		storeIdx    = 0;
		progCount   = 0;
		cycleCount  = 0;
		finished    = 1'b0;
		fillMemories();
		loadCases();

		repeat (2) begin                                        // reset cycles
			@(posedge clk);
			@(negedge clk);
			assert (pc == '0) else reportMismatch("pc", 32'd0, pc);
			assert (!writeEnable) else reportMismatch("writeEnable", 32'd0, 32'(writeEnable));
			driveInputs();
		end
		reset = 1'b0;

		while (!finished) begin
			@(posedge clk);
			cycleCount++;
			assert (cycleCount <= progCount + timeoutMargin) else begin
				$display("timeout: pc %h never reached the end address %h", pc, endPc);
				stopRun();
			end
			@(negedge clk);
			// store outputs of the completed instruction still hold
			if (writeEnable) begin
				checkStore();
			end
			checkPcStep(fetchPc, instruction);
			if (pc == endPc) begin
				finished = 1'b1;
			end else begin
				driveInputs();
			end
		end

		assert (storeIdx == storeCount) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			$display("only %0d of %0d expected stores were seen", storeIdx, storeCount);
			stopRun();
		end
	end

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  var mipsPkg::aluOp_t          op,
	input  wire [mipsPkg::wordWidth-1:0] srcA,
	input  wire [mipsPkg::wordWidth-1:0] srcB,
	output logic [mipsPkg::wordWidth-1:0] result,
	output logic                          zero
);
	import mipsPkg::*;

	localparam int laneCount = wordWidth / 8;

	logic [wordWidth-1:0] qbWrap;
	logic [wordWidth-1:0] qbSat;

	// ------------------------------------------------------------
	// quad-byte lanes, one 9-bit sum per byte
	// ------------------------------------------------------------
	always_comb begin
		logic [8:0] laneSum;

		qbWrap = '0;
		qbSat  = '0;
		for (int lane = 0; lane < laneCount; lane++) begin
			laneSum = {1'b0, srcA[lane*8 +: 8]} + {1'b0, srcB[lane*8 +: 8]};
			qbWrap[lane*8 +: 8] = laneSum[7:0];                   // modulo 256
			qbSat[lane*8 +: 8]  = laneSum[8] ? 8'hFF : laneSum[7:0];  // clamp at 255
		end
	end

	always_comb begin
		case (op)
			aluAdd:      result = srcA + srcB;
			aluSub:      result = srcA - srcB;
			aluAnd:      result = srcA & srcB;
			aluOr:       result = srcA | srcB;
			aluSlt:      result = {{(wordWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			aluQbAdd:    result = qbWrap;
			aluQbAddSat: result = qbSat;
			default:     result = '0;                              // aluNone
		endcase
	end

	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/ctrlIf.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;
	import mipsPkg::*;

	logic   regWrite;
	logic   memToReg;                                             // write back load data
	logic   regDst;                                               // rd instead of rt
	logic   aluSrc;                                               // immediate as srcB
	logic   branch;
	logic   jump;
	aluOp_t aluOp;

	modport decoder (
		output regWrite, memToReg, regDst, aluSrc, branch, jump, aluOp
	);

	modport datapath (
		input regWrite, memToReg, regDst, aluSrc, branch, jump, aluOp
	);

endinterface

`default_nettype wire

//--- design/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath (
	input  wire                           clk,
	input  wire                           reset,
	input  var mipsPkg::instr_t           instruction,
	input  wire [mipsPkg::wordWidth-1:0]  dataFromMem,
	ctrlIf.datapath                       ctrl,
	output logic [mipsPkg::wordWidth-1:0] pc,
	output logic [mipsPkg::wordWidth-1:0] addressToMem,
	output logic [mipsPkg::wordWidth-1:0] dataToMem
);
	import mipsPkg::*;

	logic [wordWidth-1:0]    readDataA;
	logic [wordWidth-1:0]    readDataB;
	logic [wordWidth-1:0]    signImm;
	logic [wordWidth-1:0]    srcB;
	logic [wordWidth-1:0]    aluResult;
	logic [wordWidth-1:0]    writeData;
	logic [regAddrWidth-1:0] writeAddr;
	logic                    zero;
	logic                    branchTaken;

	// ------------------------------------------------------------
	// operand, destination and write-back selection
	// ------------------------------------------------------------
	assign signImm   = {{(wordWidth-16){instruction.iForm.imm[15]}}, instruction.iForm.imm};
	assign srcB      = ctrl.aluSrc ? signImm : readDataB;
	assign writeAddr = ctrl.regDst ? instruction.rForm.rd : instruction.iForm.rt;
	assign writeData = ctrl.memToReg ? dataFromMem : aluResult;
	assign branchTaken = ctrl.branch && zero;                   // beq on equal operands

	assign addressToMem = aluResult;
	assign dataToMem    = readDataB;                            // rt for sw

	regFile regs (
		.clk       (clk),
		.reset     (reset),
		.readAddrA (instruction.rForm.rs),
		.readAddrB (instruction.rForm.rt),
		.writeAddr (writeAddr),
		.writeData (writeData),
		.writeEn   (ctrl.regWrite),
		.readDataA (readDataA),
		.readDataB (readDataB)
	);

	alu aluUnit (
		.op     (ctrl.aluOp),
		.srcA   (readDataA),
		.srcB   (srcB),
		.result (aluResult),
		.zero   (zero)
	);

	pcUnit pcGen (
		.clk          (clk),
		.reset        (reset),
		.branchTaken  (branchTaken),
		.jump         (ctrl.jump),
		.branchOffset (signImm),
		.jumpTarget   (instruction.jForm.target),
		.pc           (pc)
	);

endmodule

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
	input  var mipsPkg::instr_t instruction,
	input  wire                 reset,
	output logic                writeEnable,
	ctrlIf.decoder              ctrl
);
	import mipsPkg::*;

	always_comb begin
		logic isStore;

		isStore       = 1'b0;
		ctrl.regWrite = 1'b0;                                     // nop unless decoded
		ctrl.memToReg = 1'b0;
		ctrl.regDst   = 1'b0;
		ctrl.aluSrc   = 1'b0;
		ctrl.branch   = 1'b0;
		ctrl.jump     = 1'b0;
		ctrl.aluOp    = aluNone;

		case (instruction.rForm.opcode)
			opR: begin
				ctrl.regDst = 1'b1;
				case (instruction.rForm.funct)
					fnAdd:   ctrl.aluOp = aluAdd;
					fnSub:   ctrl.aluOp = aluSub;
					fnAnd:   ctrl.aluOp = aluAnd;
					fnOr:    ctrl.aluOp = aluOr;
					fnSlt:   ctrl.aluOp = aluSlt;
					default: ctrl.aluOp = aluNone;                // unknown funct
				endcase
				ctrl.regWrite = (ctrl.aluOp != aluNone);
			end
			opQb: begin
				ctrl.regDst = 1'b1;
				if (instruction.rForm.funct == fnQbAdd) begin
					case (instruction.rForm.shamt)
						shQbWrap: ctrl.aluOp = aluQbAdd;
						shQbSat:  ctrl.aluOp = aluQbAddSat;
						default:  ctrl.aluOp = aluNone;
					endcase
				end
				ctrl.regWrite = (ctrl.aluOp != aluNone);
			end
			opAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			opLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;                           // base plus offset
			end
			opSw: begin
				isStore     = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp  = aluAdd;
			end
			opBeq: begin
				ctrl.branch = 1'b1;
				ctrl.aluOp  = aluSub;                             // zero flag means equal
			end
			opJ: begin
				ctrl.jump = 1'b1;
			end
			default: begin
			end
		endcase

		writeEnable = isStore && !reset;                          // no stores while in reset
	end

endmodule

`default_nettype wire

//--- design/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
	input  wire                           clk,
	input  wire                           reset,
	output logic [mipsPkg::wordWidth-1:0] pc,
	input  wire [mipsPkg::wordWidth-1:0]  instruction,
	output logic                          writeEnable,
	output logic [mipsPkg::wordWidth-1:0] addressToMem,
	output logic [mipsPkg::wordWidth-1:0] dataToMem,
	input  wire [mipsPkg::wordWidth-1:0]  dataFromMem
);
	import mipsPkg::*;

	instr_t instrWord;

	ctrlIf ctrlBus ();

	assign instrWord = instruction;                             // raw word seen as union

	instrDecoder decoder (
		.instruction (instrWord),
		.reset       (reset),
		.writeEnable (writeEnable),
		.ctrl        (ctrlBus.decoder)
	);

	dataPath path (
		.clk          (clk),
		.reset        (reset),
		.instruction  (instrWord),
		.dataFromMem  (dataFromMem),
		.ctrl         (ctrlBus.datapath),
		.pc           (pc),
		.addressToMem (addressToMem),
		.dataToMem    (dataToMem)
	);

endmodule

`default_nettype wire

//--- design/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// ------------------------------------------------------------
	// widths and register file layout
	// ------------------------------------------------------------
	localparam int wordWidth    = 32;
	localparam int regAddrWidth = 5;
	localparam int regCount     = 32;
	localparam int spIndex      = 29;                             // stack pointer
	localparam logic [wordWidth-1:0] stackInit = 32'h0000_4000;

	// ------------------------------------------------------------
	// opcode, function and shift-amount encodings
	// ------------------------------------------------------------
	localparam logic [5:0] opR    = 6'b000000;
	localparam logic [5:0] opQb   = 6'b011111;                    // packed byte ops
	localparam logic [5:0] opAddi = 6'b001000;
	localparam logic [5:0] opLw   = 6'b100011;
	localparam logic [5:0] opSw   = 6'b101011;
	localparam logic [5:0] opBeq  = 6'b000100;
	localparam logic [5:0] opJ    = 6'b000010;

	localparam logic [5:0] fnAdd   = 6'b100000;
	localparam logic [5:0] fnSub   = 6'b100010;
	localparam logic [5:0] fnAnd   = 6'b100100;
	localparam logic [5:0] fnOr    = 6'b100101;
	localparam logic [5:0] fnSlt   = 6'b101010;
	localparam logic [5:0] fnQbAdd = 6'b010000;

	localparam logic [4:0] shQbWrap = 5'b00000;                   // addu.qb
	localparam logic [4:0] shQbSat  = 5'b00100;                   // addu_s.qb

	typedef enum logic [3:0] {
		aluAnd      = 4'b0000,
		aluOr       = 4'b0001,
		aluAdd      = 4'b0010,
		aluSub      = 4'b0110,
		aluSlt      = 4'b0111,
		aluQbAdd    = 4'b1000,
		aluQbAddSat = 4'b1001,
		aluNone     = 4'b1111
	} aluOp_t;

	// ------------------------------------------------------------
	// instruction word formats
	// ------------------------------------------------------------
	typedef struct packed {
		logic [5:0]              opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} rFields_t;

	typedef struct packed {
		logic [5:0]              opcode;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0]             imm;
	} iFields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target;
	} jFields_t;

	typedef union packed {
		rFields_t rForm;
		iFields_t iForm;
		jFields_t jForm;
	} instr_t;

endpackage

`default_nettype wire

//--- design/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           branchTaken,
	input  wire                           jump,
	input  wire [mipsPkg::wordWidth-1:0]  branchOffset,
	input  wire [25:0]                    jumpTarget,
	output logic [mipsPkg::wordWidth-1:0] pc
);
	import mipsPkg::*;

	logic [wordWidth-1:0] pcPlus4;
	logic [wordWidth-1:0] branchAddr;
	logic [wordWidth-1:0] jumpAddr;
	logic [wordWidth-1:0] pcNext;

	assign pcPlus4    = pc + 32'd4;
	assign branchAddr = pcPlus4 + {branchOffset[wordWidth-3:0], 2'b00};  // offset in words
	assign jumpAddr   = {pcPlus4[wordWidth-1:wordWidth-4], jumpTarget, 2'b00};

	always_comb begin
		if (jump) begin
			pcNext = jumpAddr;
		end else if (branchTaken) begin
			pcNext = branchAddr;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= pcNext;
		end
	end

	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- design/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire                                clk,
	input  wire                                reset,
	input  wire [mipsPkg::regAddrWidth-1:0]    readAddrA,
	input  wire [mipsPkg::regAddrWidth-1:0]    readAddrB,
	input  wire [mipsPkg::regAddrWidth-1:0]    writeAddr,
	input  wire [mipsPkg::wordWidth-1:0]       writeData,
	input  wire                                writeEn,
	output logic [mipsPkg::wordWidth-1:0]      readDataA,
	output logic [mipsPkg::wordWidth-1:0]      readDataB
);
	import mipsPkg::*;

	logic [wordWidth-1:0] regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int idx = 0; idx < regCount; idx++) begin
				regs[idx] <= (idx == spIndex) ? stackInit : '0;   // sp gets its start value
			end
		end else if (writeEn && writeAddr != '0) begin        // $0 stays zero
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	zeroRegA: assert property (@(posedge clk) disable iff (reset)
		(readAddrA == '0) |-> (readDataA == '0));
	zeroRegB: assert property (@(posedge clk) disable iff (reset)
		(readAddrB == '0) |-> (readDataB == '0));

endmodule

`default_nettype wire

//--- project.f
design/mipsPkg.sv
design/ctrlIf.sv
design/instrDecoder.sv
design/alu.sv
design/regFile.sv
design/pcUnit.sv
design/dataPath.sv
design/mipsCore.sv
bench/mipsCoreTb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mipsCoreTb -f project.f -o mipsCoreSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mipsCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi

echo "pass line not found in sim.log"
exit 1
